// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;     // data or address word
	typedef logic [4:0]      reg_addr_t; // register index
	typedef logic [3:0]      strb_t;     // one bit per byte lane
	typedef logic [2:0]      funct3_t;
	typedef logic [6:0]      funct7_t;

	// major opcodes of the kept rv32i subset
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_t;

	localparam funct3_t f3_add  = 3'b000; // add, sub, addi
	localparam funct3_t f3_sll  = 3'b001;
	localparam funct3_t f3_slt  = 3'b010;
	localparam funct3_t f3_sltu = 3'b011;
	localparam funct3_t f3_xor  = 3'b100;
	localparam funct3_t f3_sr   = 3'b101; // srl and sra
	localparam funct3_t f3_or   = 3'b110;
	localparam funct3_t f3_and  = 3'b111;

	localparam funct3_t f3_jalr = 3'b000;

	localparam funct3_t f3_beq  = 3'b000;
	localparam funct3_t f3_bne  = 3'b001;
	localparam funct3_t f3_blt  = 3'b100;
	localparam funct3_t f3_bge  = 3'b101;
	localparam funct3_t f3_bltu = 3'b110;
	localparam funct3_t f3_bgeu = 3'b111;

	// access sizes, shared by loads and stores
	localparam funct3_t f3_byte   = 3'b000;
	localparam funct3_t f3_half   = 3'b001;
	localparam funct3_t f3_word   = 3'b010;
	localparam funct3_t f3_byte_u = 3'b100;
	localparam funct3_t f3_half_u = 3'b101;

	localparam funct7_t f7_base = 7'b0000000;
	localparam funct7_t f7_alt  = 7'b0100000; // sub and sra

endpackage

// File: source/core_pkg.sv
package core_pkg;

	// decoder outcome, consumed by the register read unit and execute
	typedef struct packed {
		rv_isa_pkg::opcode_t   opcode;
		rv_isa_pkg::funct3_t   funct3;
		rv_isa_pkg::reg_addr_t rd;
		rv_isa_pkg::reg_addr_t rs1;
		rv_isa_pkg::reg_addr_t rs2;
		logic                  rs1_used;
		logic                  rs2_used;
		logic                  rd_used;
		rv_isa_pkg::word_t     imm;          // already in its format
		logic                  legal;
		logic                  sub_or_arith; // funct7 bit 5
	} decoded_t;

	// data memory request
	typedef struct packed {
		logic              valid;
		rv_isa_pkg::word_t addr;
		rv_isa_pkg::word_t wdata;
		rv_isa_pkg::strb_t wstrb;
		rv_isa_pkg::strb_t rmask;
	} mem_req_t;

	// per operand tracker
	typedef enum logic [1:0] {
		st_idle,
		st_reading,
		st_ready
	} operand_state_t;

endpackage

// File: source/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
	input  rv_isa_pkg::word_t  insn,
	output core_pkg::decoded_t dec
);

	rv_isa_pkg::opcode_t opcode;
	rv_isa_pkg::funct3_t funct3;
	rv_isa_pkg::funct7_t funct7;
	rv_isa_pkg::word_t   imm_i;
	rv_isa_pkg::word_t   imm_s;
	rv_isa_pkg::word_t   imm_b;
	rv_isa_pkg::word_t   imm_j;
	rv_isa_pkg::word_t   imm_u;
	rv_isa_pkg::word_t   imm;
	logic                legal;
	logic                rs1_used;
	logic                rs2_used;
	logic                rd_used;

	assign opcode = rv_isa_pkg::opcode_t'(insn[6:0]);
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};

	always_comb begin
		legal    = 1'b0;
		rs1_used = 1'b0;
		rs2_used = 1'b0;
		rd_used  = 1'b0;
		imm      = imm_i;
		case (opcode)
			rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc: begin
				legal   = 1'b1;
				rd_used = 1'b1;
				imm     = imm_u;
			end
			rv_isa_pkg::op_jal: begin
				legal   = 1'b1;
				rd_used = 1'b1;
				imm     = imm_j;
			end
			rv_isa_pkg::op_jalr: begin
				legal    = (funct3 == rv_isa_pkg::f3_jalr);
				rs1_used = 1'b1;
				rd_used  = 1'b1;
			end
			rv_isa_pkg::op_branch: begin
				legal = funct3 inside {rv_isa_pkg::f3_beq, rv_isa_pkg::f3_bne,
					rv_isa_pkg::f3_blt, rv_isa_pkg::f3_bge,
					rv_isa_pkg::f3_bltu, rv_isa_pkg::f3_bgeu};
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				imm      = imm_b;
			end
			rv_isa_pkg::op_load: begin
				legal = funct3 inside {rv_isa_pkg::f3_byte, rv_isa_pkg::f3_half,
					rv_isa_pkg::f3_word, rv_isa_pkg::f3_byte_u, rv_isa_pkg::f3_half_u};
				rs1_used = 1'b1;
				rd_used  = 1'b1;
			end
			rv_isa_pkg::op_store: begin
				legal = funct3 inside {rv_isa_pkg::f3_byte, rv_isa_pkg::f3_half,
					rv_isa_pkg::f3_word};
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				imm      = imm_s;
			end
			rv_isa_pkg::op_imm: begin
				rs1_used = 1'b1;
				rd_used  = 1'b1;
				if (funct3 == rv_isa_pkg::f3_sll)
					legal = (funct7 == rv_isa_pkg::f7_base); // shamt[5] must be clear
				else if (funct3 == rv_isa_pkg::f3_sr)
					legal = (funct7 == rv_isa_pkg::f7_base) || (funct7 == rv_isa_pkg::f7_alt);
				else
					legal = 1'b1;
			end
			rv_isa_pkg::op_reg: begin
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				rd_used  = 1'b1;
				legal = (funct7 == rv_isa_pkg::f7_base) || ((funct7 == rv_isa_pkg::f7_alt)
					&& (funct3 == rv_isa_pkg::f3_add || funct3 == rv_isa_pkg::f3_sr));
			end
			default: legal = 1'b0; // unknown opcode
		endcase
	end

	// illegal encodings request no operands and write nothing
	always_comb begin
		dec              = '0;
		dec.opcode       = opcode;
		dec.funct3       = funct3;
		dec.rd           = insn[11:7];
		dec.rs1          = insn[19:15];
		dec.rs2          = insn[24:20];
		dec.rs1_used     = legal && rs1_used;
		dec.rs2_used     = legal && rs2_used;
		dec.rd_used      = legal && rd_used;
		dec.imm          = imm;
		dec.legal        = legal;
		dec.sub_or_arith = insn[30];
	end

endmodule

// File: source/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
	input  core_pkg::decoded_t dec,
	input  rv_isa_pkg::word_t  rs1_data,
	input  rv_isa_pkg::word_t  rs2_data,
	output rv_isa_pkg::word_t  alu_result,
	output logic               branch_taken
);

	rv_isa_pkg::word_t b;
	logic [4:0]        shamt;
	logic signed [rv_isa_pkg::XLEN-1:0] sra_val;
	logic              eq;
	logic              lt;
	logic              ltu;

	assign b     = (dec.opcode == rv_isa_pkg::op_imm) ? dec.imm : rs2_data;
	assign shamt = b[4:0];

	assign sra_val = $signed(rs1_data) >>> shamt;
	assign eq      = (rs1_data == b);
	assign lt      = ($signed(rs1_data) < $signed(b));
	assign ltu     = (rs1_data < b);

	always_comb begin
		case (dec.funct3)
			rv_isa_pkg::f3_add: begin
				if (dec.opcode == rv_isa_pkg::op_reg && dec.sub_or_arith)
					alu_result = rs1_data - b;
				else
					alu_result = rs1_data + b; // addi ignores bit 30
			end
			rv_isa_pkg::f3_sll:  alu_result = rs1_data << shamt;
			rv_isa_pkg::f3_slt:  alu_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt};
			rv_isa_pkg::f3_sltu: alu_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, ltu};
			rv_isa_pkg::f3_xor:  alu_result = rs1_data ^ b;
			rv_isa_pkg::f3_sr:   alu_result = dec.sub_or_arith ? sra_val : (rs1_data >> shamt);
			rv_isa_pkg::f3_or:   alu_result = rs1_data | b;
			default:             alu_result = rs1_data & b; // f3_and
		endcase
	end

	// b is rs2 for branches
	always_comb begin
		case (dec.funct3)
			rv_isa_pkg::f3_beq:  branch_taken = eq;
			rv_isa_pkg::f3_bne:  branch_taken = !eq;
			rv_isa_pkg::f3_blt:  branch_taken = lt;
			rv_isa_pkg::f3_bge:  branch_taken = !lt;
			rv_isa_pkg::f3_bltu: branch_taken = ltu;
			rv_isa_pkg::f3_bgeu: branch_taken = !ltu;
			default:             branch_taken = 1'b0;
		endcase
	end

endmodule

// File: source/rv_execute.sv
`timescale 1ns/1ns

module rv_execute #(
	parameter rv_isa_pkg::word_t RESET_PC = 32'h10000
) (
	input  logic                clk,
	input  logic                resetn,
	input  logic                insn_valid,
	input  core_pkg::decoded_t  dec,
	input  rv_isa_pkg::word_t   rs1_data,
	input  logic                rs2_ready,
	input  logic                rs1_ready,
	input  rv_isa_pkg::word_t   rs2_data,
	input  rv_isa_pkg::word_t   alu_result,
	input  logic                branch_taken,
	input  logic                mem_ready,
	input  rv_isa_pkg::word_t   mem_rdata,
	output rv_isa_pkg::word_t   insn_addr,
	output core_pkg::mem_req_t  mem_req,
	output rv_isa_pkg::word_t   wb_data,
	output logic                retire,
	output logic                trap
);

	rv_isa_pkg::word_t pc;
	rv_isa_pkg::word_t pc_plus4;
	rv_isa_pkg::word_t target;
	rv_isa_pkg::word_t next_pc;
	rv_isa_pkg::word_t load_data;
	rv_isa_pkg::strb_t size_mask;
	logic              is_load;
	logic              is_store;
	logic              mem_access;
	logic              misaligned;
	logic              rs1_ok;
	logic              rs2_ok;

	assign is_load   = (dec.opcode == rv_isa_pkg::op_load);
	assign is_store  = (dec.opcode == rv_isa_pkg::op_store);
	assign pc_plus4  = pc + 32'd4;
	assign insn_addr = pc;

	always_comb begin
		case (dec.opcode)
			rv_isa_pkg::op_jal:    target = pc + dec.imm;
			rv_isa_pkg::op_jalr:   target = (rs1_data + dec.imm) & 32'hffff_fffe;
			rv_isa_pkg::op_branch: target = branch_taken ? pc + dec.imm : pc_plus4;
			default:               target = pc_plus4;
		endcase
	end

	assign misaligned = (target[1:0] != 2'b00);
	assign trap       = insn_valid && (!dec.legal || misaligned);
	assign next_pc    = trap ? pc : target; // park on the faulting insn

	// retire once operands and memory are done
	assign rs1_ok     = !dec.rs1_used || rs1_ready;
	assign rs2_ok     = !dec.rs2_used || rs2_ready;
	assign mem_access = insn_valid && dec.legal && (is_load || is_store);
	assign retire     = insn_valid && rs1_ok && rs2_ok && (!mem_access || mem_ready);

	always_comb begin
		case (dec.funct3)
			rv_isa_pkg::f3_byte, rv_isa_pkg::f3_byte_u: size_mask = 4'b0001;
			rv_isa_pkg::f3_half, rv_isa_pkg::f3_half_u: size_mask = 4'b0011;
			rv_isa_pkg::f3_word:                        size_mask = 4'b1111;
			default:                                    size_mask = 4'b0000;
		endcase
	end

	always_comb begin
		mem_req       = '0;
		mem_req.valid = mem_access;
		mem_req.addr  = rs1_data + dec.imm;
		mem_req.wdata = rs2_data;
		mem_req.wstrb = (is_store && retire) ? size_mask : 4'b0000; // write only when committing
		mem_req.rmask = is_load ? size_mask : 4'b0000;
	end

	always_comb begin
		case (dec.funct3)
			rv_isa_pkg::f3_byte:   load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			rv_isa_pkg::f3_byte_u: load_data = {24'b0, mem_rdata[7:0]};
			rv_isa_pkg::f3_half:   load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			rv_isa_pkg::f3_half_u: load_data = {16'b0, mem_rdata[15:0]};
			default:               load_data = mem_rdata;
		endcase
	end

	always_comb begin
		case (dec.opcode)
			rv_isa_pkg::op_lui:                     wb_data = dec.imm;
			rv_isa_pkg::op_auipc:                   wb_data = pc + dec.imm;
			rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr: wb_data = pc_plus4; // link
			rv_isa_pkg::op_load:                    wb_data = load_data;
			default:                                wb_data = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pc <= RESET_PC;
		end else if (retire) begin
			pc <= next_pc;
		end
	end

endmodule

// File: source/reg_read_unit.sv
`timescale 1ns/1ns

module reg_read_unit #(
	parameter rv_isa_pkg::word_t STACK_ADDR   = 32'h10000,
	parameter int                READ_LATENCY = 3
) (
	input  logic               clk,
	input  logic               resetn,
	input  logic               insn_valid,
	input  core_pkg::decoded_t dec,
	input  logic               retire,
	input  rv_isa_pkg::word_t  wb_data,
	output rv_isa_pkg::word_t  rs1_data,
	output rv_isa_pkg::word_t  rs2_data,
	output logic               rs1_ready,
	output logic               rs2_ready
);

	rv_isa_pkg::word_t         regs [32];
	core_pkg::operand_state_t  rs1_state;
	core_pkg::operand_state_t  rs2_state;
	logic [1:0]                req;
	logic [1:0]                gnt;  // bit 0 is rs1
	rv_isa_pkg::reg_addr_t     read_idx;
	logic [1:0]                gnt_pipe [READ_LATENCY];
	rv_isa_pkg::word_t         data_pipe [READ_LATENCY];
	logic [1:0]                back;
	rv_isa_pkg::word_t         back_data;
	rv_isa_pkg::word_t         rs1_q;
	rv_isa_pkg::word_t         rs2_q;

	function automatic core_pkg::operand_state_t track(
		input core_pkg::operand_state_t st,
		input logic                     grant,
		input logic                     returned,
		input logic                     done
	);
		core_pkg::operand_state_t nxt;
		nxt = st;
		case (st)
			core_pkg::st_idle:    if (grant) nxt = core_pkg::st_reading;
			core_pkg::st_reading: if (returned) nxt = core_pkg::st_ready;
			core_pkg::st_ready:   if (done) nxt = core_pkg::st_idle;
			default:              nxt = core_pkg::st_idle;
		endcase
		return nxt;
	endfunction

	// x0 never goes through the read path
	assign req[0] = insn_valid && dec.rs1_used && (dec.rs1 != 5'd0)
		&& (rs1_state == core_pkg::st_idle);
	assign req[1] = insn_valid && dec.rs2_used && (dec.rs2 != 5'd0)
		&& (rs2_state == core_pkg::st_idle);

	// fixed priority, one read port
	assign gnt[0]   = req[0];
	assign gnt[1]   = req[1] && !req[0];
	assign read_idx = gnt[0] ? dec.rs1 : dec.rs2;

	assign back      = gnt_pipe[READ_LATENCY-1];
	assign back_data = data_pipe[READ_LATENCY-1];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < READ_LATENCY; i++)
				gnt_pipe[i] <= 2'b00;
		end else begin
			gnt_pipe[0] <= gnt;
			for (int i = 1; i < READ_LATENCY; i++)
				gnt_pipe[i] <= gnt_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		data_pipe[0] <= regs[read_idx];
		for (int i = 1; i < READ_LATENCY; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rs1_state <= core_pkg::st_idle;
			rs2_state <= core_pkg::st_idle;
		end else begin
			rs1_state <= track(rs1_state, gnt[0], back[0], retire);
			rs2_state <= track(rs2_state, gnt[1], back[1], retire);
		end
	end

	always_ff @(posedge clk) begin
		if (back[0])
			rs1_q <= back_data;
		if (back[1])
			rs2_q <= back_data;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			regs[0] <= '0;
			regs[2] <= STACK_ADDR; // sp
		end else if (retire && dec.rd_used && (dec.rd != 5'd0)) begin
			regs[dec.rd] <= wb_data;
		end
	end

	assign rs1_data  = (dec.rs1 == 5'd0) ? '0 : rs1_q;
	assign rs2_data  = (dec.rs2 == 5'd0) ? '0 : rs2_q;
	assign rs1_ready = (rs1_state == core_pkg::st_ready) || (dec.rs1 == 5'd0);
	assign rs2_ready = (rs2_state == core_pkg::st_ready) || (dec.rs2 == 5'd0);

endmodule

// File: source/minrv32_top.sv
`timescale 1ns/1ns

module minrv32_top #(
	parameter rv_isa_pkg::word_t RESET_PC     = 32'h10000,
	parameter rv_isa_pkg::word_t STACK_ADDR   = 32'h10000,
	parameter int                READ_LATENCY = 3
) (
	input  logic              clk,
	input  logic              resetn,
	input  rv_isa_pkg::word_t insn,
	input  logic              insn_valid,
	output rv_isa_pkg::word_t insn_addr,
	output logic              mem_valid,
	output rv_isa_pkg::word_t mem_addr,
	output rv_isa_pkg::word_t mem_wdata,
	output rv_isa_pkg::strb_t mem_wstrb,
	output rv_isa_pkg::strb_t mem_rmask,
	input  logic              mem_ready,
	input  rv_isa_pkg::word_t mem_rdata,
	output logic              retire,
	output logic              trap
);

	core_pkg::decoded_t dec;
	core_pkg::mem_req_t mem_req;
	rv_isa_pkg::word_t  rs1_data;
	rv_isa_pkg::word_t  rs2_data;
	rv_isa_pkg::word_t  alu_result;
	rv_isa_pkg::word_t  wb_data;
	logic               rs1_ready;
	logic               rs2_ready;
	logic               branch_taken;

	rv_decoder rv_decoder_inst (
		.insn (insn),
		.dec  (dec)
	);

	reg_read_unit #(
		.STACK_ADDR   (STACK_ADDR),
		.READ_LATENCY (READ_LATENCY)
	) reg_read_unit_inst (
		.clk        (clk),
		.resetn     (resetn),
		.insn_valid (insn_valid),
		.dec        (dec),
		.retire     (retire),
		.wb_data    (wb_data),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.rs1_ready  (rs1_ready),
		.rs2_ready  (rs2_ready)
	);

	rv_alu rv_alu_inst (
		.dec          (dec),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.alu_result   (alu_result),
		.branch_taken (branch_taken)
	);

	rv_execute #(
		.RESET_PC (RESET_PC)
	) rv_execute_inst (
		.clk          (clk),
		.resetn       (resetn),
		.insn_valid   (insn_valid),
		.dec          (dec),
		.rs1_data     (rs1_data),
		.rs2_ready    (rs2_ready),
		.rs1_ready    (rs1_ready),
		.rs2_data     (rs2_data),
		.alu_result   (alu_result),
		.branch_taken (branch_taken),
		.mem_ready    (mem_ready),
		.mem_rdata    (mem_rdata),
		.insn_addr    (insn_addr),
		.mem_req      (mem_req),
		.wb_data      (wb_data),
		.retire       (retire),
		.trap         (trap)
	);

	// memory pins
	assign mem_valid = mem_req.valid;
	assign mem_addr  = mem_req.addr;
	assign mem_wdata = mem_req.wdata;
	assign mem_wstrb = mem_req.wstrb;
	assign mem_rmask = mem_req.rmask;

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic resetn
);

	initial begin
		clk    = 1'b0;
		resetn = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (RESET_CYCLES) @(posedge clk);
		#1 resetn = 1'b1; // released just after an edge
	end

endmodule

// File: verif/minrv32_tb.sv
`timescale 1ns/1ns

module minrv32_tb;

	localparam rv_isa_pkg::word_t RESET_PC = 32'h10000;
	localparam rv_isa_pkg::word_t BASE     = 32'h10000; // x2 after reset
	localparam rv_isa_pkg::word_t VAL_A    = 32'h12345678;
	localparam rv_isa_pkg::word_t VAL_B    = 32'hfffffffb;
	localparam int                TIMEOUT  = 40;

	typedef struct packed {
		int                id;
		rv_isa_pkg::word_t insn;
		rv_isa_pkg::word_t ldata;
		int                stall;     // cycles with mem_ready low
		rv_isa_pkg::word_t exp_next;  // insn_addr after retire
		logic              is_mem;
		rv_isa_pkg::word_t exp_maddr;
		logic              chk_wdata;
		rv_isa_pkg::word_t exp_wdata;
		rv_isa_pkg::strb_t exp_wstrb;
		rv_isa_pkg::strb_t exp_rmask;
		logic              exp_trap;
	} row_t;

	logic              clk;
	logic              resetn;
	rv_isa_pkg::word_t insn;
	logic              insn_valid;
	rv_isa_pkg::word_t insn_addr;
	logic              mem_valid;
	rv_isa_pkg::word_t mem_addr;
	rv_isa_pkg::word_t mem_wdata;
	rv_isa_pkg::strb_t mem_wstrb;
	rv_isa_pkg::strb_t mem_rmask;
	logic              mem_ready;
	rv_isa_pkg::word_t mem_rdata;
	logic              retire;
	logic              trap;

	row_t              table_q[$];
	rv_isa_pkg::word_t cur_pc;
	int                store_off;
	logic [31:0]       lcg_state;
	int                errors;
	int                checks;

	tb_clock #(.PERIOD(8), .RESET_CYCLES(2)) tb_clock_inst (
		.clk    (clk),
		.resetn (resetn)
	);

	minrv32_top #(.RESET_PC(RESET_PC), .STACK_ADDR(BASE), .READ_LATENCY(3)) minrv32_top_inst (
		.clk        (clk),
		.resetn     (resetn),
		.insn       (insn),
		.insn_valid (insn_valid),
		.insn_addr  (insn_addr),
		.mem_valid  (mem_valid),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_wstrb  (mem_wstrb),
		.mem_rmask  (mem_rmask),
		.mem_ready  (mem_ready),
		.mem_rdata  (mem_rdata),
		.retire     (retire),
		.trap       (trap)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// instruction encoders
	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic add_row(logic [31:0] i, logic [31:0] ld, int stall, logic [31:0] nxt,
		logic is_mem, logic [31:0] maddr, logic chk_wd, logic [31:0] wd, logic [3:0] strb,
		logic [3:0] rmask, logic trp);
		row_t r;
		r = '{table_q.size(), i, ld, stall, nxt, is_mem, maddr, chk_wd, wd, strb, rmask, trp};
		table_q.push_back(r);
		cur_pc = nxt;
	endtask

	task automatic add_op(logic [31:0] i);
		add_row(i, '0, 0, cur_pc + 4, 1'b0, '0, 1'b0, '0, 4'b0000, 4'b0000, 1'b0);
	endtask

	task automatic add_store(logic [4:0] rs2, logic [31:0] wd, int stall);
		add_row(enc_s(store_off[11:0], rs2, 5'd2, 3'b010), '0, stall, cur_pc + 4, 1'b1,
			BASE + store_off, 1'b1, wd, 4'b1111, 4'b0000, 1'b0);
		store_off = (store_off + 4) % 64;
	endtask

	task automatic op_then_store(logic [31:0] i, logic [31:0] expected, int stall);
		add_op(i);
		add_store(5'd7, expected, stall);
	endtask

	task automatic add_branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, logic taken);
		add_row(enc_b(13'd8, rs2, rs1, f3), '0, 0, taken ? cur_pc + 8 : cur_pc + 4, 1'b0, '0,
			1'b0, '0, 4'b0000, 4'b0000, 1'b0);
	endtask

	task automatic add_load(logic [2:0] f3, logic [3:0] rmask, logic [31:0] ld,
		logic [31:0] expected, int stall);
		add_row(enc_i(12'h020, 5'd2, f3, 5'd9, 7'b0000011), ld, stall, cur_pc + 4, 1'b1,
			BASE + 32'h20, 1'b0, '0, 4'b0000, rmask, 1'b0);
		add_store(5'd9, expected, 0);
	endtask

	task automatic add_trap(logic [31:0] i);
		add_row(i, '0, 0, cur_pc, 1'b0, '0, 1'b0, '0, 4'b0000, 4'b0000, 1'b1);
	endtask

	task automatic build_table();
		logic [31:0] v;
		logic [31:0] link;
		cur_pc    = RESET_PC;
		store_off = 0;
		// x5 holds A, x6 holds B and x8 holds 4
		add_op({20'h12345, 5'd5, 7'b0110111});
		add_op(enc_i(12'h678, 5'd5, 3'b000, 5'd5, 7'b0010011));
		add_op(enc_i(12'hffb, 5'd0, 3'b000, 5'd6, 7'b0010011));
		add_op(enc_i(12'h004, 5'd0, 3'b000, 5'd8, 7'b0010011));
		add_store(5'd5, VAL_A, 0);
		op_then_store(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd7), VAL_A + VAL_B, 0);
		op_then_store(enc_r(7'h20, 5'd6, 5'd5, 3'b000, 5'd7), VAL_A - VAL_B, 6); // stalled
		op_then_store(enc_r(7'h00, 5'd6, 5'd5, 3'b100, 5'd7), VAL_A ^ VAL_B, 0);
		op_then_store(enc_r(7'h00, 5'd6, 5'd5, 3'b110, 5'd7), VAL_A | VAL_B, 0);
		op_then_store(enc_r(7'h00, 5'd6, 5'd5, 3'b111, 5'd7), VAL_A & VAL_B, 0);
		op_then_store(enc_r(7'h00, 5'd5, 5'd6, 3'b010, 5'd7), 32'd1, 0);  // -5 < A
		op_then_store(enc_r(7'h00, 5'd5, 5'd6, 3'b011, 5'd7), 32'd0, 0);
		op_then_store(enc_r(7'h00, 5'd8, 5'd5, 3'b001, 5'd7), VAL_A << 4, 0);
		op_then_store(enc_r(7'h00, 5'd8, 5'd6, 3'b101, 5'd7), VAL_B >> 4, 0);
		op_then_store(enc_r(7'h20, 5'd8, 5'd6, 3'b101, 5'd7), {4'hf, VAL_B[31:4]}, 0);
		op_then_store(enc_i({7'h20, 5'd1}, 5'd6, 3'b101, 5'd7, 7'b0010011),
			{1'b1, VAL_B[31:1]}, 7);
		// every branch condition taken then not taken
		add_branch(3'b000, 5'd5, 5'd5, 1'b1);
		add_branch(3'b000, 5'd5, 5'd6, 1'b0);
		add_branch(3'b001, 5'd5, 5'd6, 1'b1);
		add_branch(3'b001, 5'd5, 5'd5, 1'b0);
		add_branch(3'b100, 5'd6, 5'd5, 1'b1);
		add_branch(3'b100, 5'd5, 5'd6, 1'b0);
		add_branch(3'b101, 5'd5, 5'd6, 1'b1);
		add_branch(3'b101, 5'd6, 5'd5, 1'b0);
		add_branch(3'b110, 5'd5, 5'd6, 1'b1);
		add_branch(3'b110, 5'd6, 5'd5, 1'b0);
		add_branch(3'b111, 5'd6, 5'd5, 1'b1);
		add_branch(3'b111, 5'd5, 5'd6, 1'b0);
		// sign bits forced on for the signed loads
		v = lcg_next();
		add_load(3'b010, 4'b1111, v, v, 6);
		v = lcg_next() | 32'h80;
		add_load(3'b000, 4'b0001, v, {{24{1'b1}}, v[7:0]}, 0);
		v = lcg_next();
		add_load(3'b100, 4'b0001, v, {24'h0, v[7:0]}, 0);
		v = lcg_next() | 32'h8000;
		add_load(3'b001, 4'b0011, v, {{16{1'b1}}, v[15:0]}, 0);
		v = lcg_next();
		add_load(3'b101, 4'b0011, v, {16'h0, v[15:0]}, 0);
		// narrow stores
		add_row(enc_s(12'h008, 5'd5, 5'd2, 3'b000), '0, 0, cur_pc + 4, 1'b1, BASE + 8,
			1'b1, VAL_A, 4'b0001, 4'b0000, 1'b0);
		add_row(enc_s(12'h00c, 5'd5, 5'd2, 3'b001), '0, 7, cur_pc + 4, 1'b1, BASE + 12,
			1'b1, VAL_A, 4'b0011, 4'b0000, 1'b0);
		// jumps and their link values
		link = cur_pc + 4;
		add_row(enc_j(21'd16, 5'd10), '0, 0, cur_pc + 16, 1'b0, '0, 1'b0, '0, 4'b0, 4'b0,
			1'b0);
		add_store(5'd10, link, 0);
		add_op({20'h00020, 5'd12, 7'b0110111}); // x12 = 0x20000
		link = cur_pc + 4;
		add_row(enc_i(12'h100, 5'd12, 3'b000, 5'd11, 7'b1100111), '0, 0, 32'h20100, 1'b0, '0,
			1'b0, '0, 4'b0, 4'b0, 1'b0);
		add_store(5'd11, link, 0);
		v = cur_pc + 32'h1000;
		add_op({20'h00001, 5'd7, 7'b0010111}); // auipc
		add_store(5'd7, v, 0);
		// traps park the pc
		add_trap(enc_i(12'h102, 5'd12, 3'b000, 5'd11, 7'b1100111));
		add_trap(32'hffff_ffff);
		add_trap(32'h0000_0000);
		add_trap(enc_r(7'h01, 5'd6, 5'd5, 3'b000, 5'd7));
		op_then_store(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd7), VAL_A + VAL_B, 0);
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic run_row(row_t r);
		int   cycles;
		int   errs_before;
		logic done;
		errs_before = errors;
		cycles      = 0;
		done        = 1'b0;
		insn        = r.insn;
		insn_valid  = 1'b1;
		mem_rdata   = r.ldata;
		mem_ready   = (r.stall == 0);
		while (!done && cycles < TIMEOUT) begin
			@(negedge clk);
			if (!mem_ready) begin
				check_value("retire", retire, 1'b0); // held off by memory
				check_value("mem_wstrb", mem_wstrb, 4'b0000);
			end else if (retire) begin
				done = 1'b1;
				check_value("trap", trap, r.exp_trap);
				check_value("mem_valid", mem_valid, r.is_mem);
				check_value("mem_wstrb", mem_wstrb, r.exp_wstrb);
				check_value("mem_rmask", mem_rmask, r.exp_rmask);
				if (r.is_mem)
					check_value("mem_addr", mem_addr, r.exp_maddr);
				if (r.chk_wdata)
					check_value("mem_wdata", mem_wdata, r.exp_wdata);
			end
			@(posedge clk);
			#1;
			cycles++;
			if (cycles >= r.stall)
				mem_ready = 1'b1;
		end
		if (!done) begin
			errors++;
			$display("test %0d: no retire within %0d cycles", r.id, TIMEOUT);
		end
		check_value("insn_addr", insn_addr, r.exp_next);
		$display("test %0d insn %h: %s", r.id, r.insn, (errors == errs_before) ? "ok" : "failed");
	endtask

	initial begin
		int wait_cnt;
		insn       = '0;
		insn_valid = 1'b0;
		mem_ready  = 1'b1;
		mem_rdata  = '0;
		lcg_state  = 32'd14;
		errors     = 0;
		checks     = 0;
		build_table();
		wait_cnt = 0;
		while (!resetn && wait_cnt < TIMEOUT) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (!resetn) begin
			errors++;
			$display("reset never released");
		end
		@(posedge clk);
		#1;
		// state right after reset
		check_value("insn_addr", insn_addr, RESET_PC);
		check_value("retire", retire, 1'b0);
		check_value("trap", trap, 1'b0);
		check_value("mem_valid", mem_valid, 1'b0);
		foreach (table_q[k])
			run_row(table_q[k]);
		insn_valid = 1'b0;
		$display("%0d tests, %0d checks, %0d errors", table_q.size(), checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: filelist.f
source/rv_isa_pkg.sv
source/core_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_execute.sv
source/reg_read_unit.sv
source/minrv32_top.sv
verif/tb_clock.sv
verif/minrv32_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= minrv32_tb
RTL_TOP   ?= minrv32_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
